// File: include/rcc_bdcr_defs.svh
`ifndef RCC_BDCR_DEFS_SVH
`define RCC_BDCR_DEFS_SVH

// ============================================================
// backup domain control word
// ============================================================

`define RCC_BDCR_W 16 // bdcr word width

// reset value of shadow and switched-domain registers
`define RCC_BDCR_RST 16'h0000

// ============================================================
// crossing timing
// ============================================================

// cycles the next value is held stable before the commit strobe
`define RCC_SETTLE_CYCLES 4

`endif

// File: logic/rcc_bdcr_pkg.sv
package rcc_bdcr_pkg;

  `include "rcc_bdcr_defs.svh"

  // ============================================================
  // bdcr field layout, msb first
  // ============================================================
  typedef struct packed {
    logic       bdrst;      // backup domain reset
    logic [3:0] rsvd_14_11;
    logic       rtcen;      // rtc clock enable
    logic [1:0] rtcsel;     // rtc clock source
    logic       rsvd_7;
    logic       lsecssd;    // css detect, read only
    logic       lsecsson;   // css enable
    logic [1:0] lsedrv;     // lse drive strength
    logic       lsebyp;     // lse bypass
    logic       rsvd_1;
    logic       lseon;      // lse enable
  } bdcr_fields_t;

  // raw word at the software side, field view in the switched domain
  typedef union packed {
    logic [`RCC_BDCR_W-1:0] raw;
    bdcr_fields_t           f;
  } bdcr_u;

  // ============================================================
  // write sequencer
  // ============================================================
  typedef enum logic [1:0] {
    IDLE   = 2'd0, // ready for a software write
    DRIVE  = 2'd1, // next value presented on the crossing
    SETTLE = 2'd2, // waiting out the settle window
    COMMIT = 2'd3  // load strobe to switched domain
  } bdcr_state_e;

endpackage

// File: logic/rcc_bdcr_if.sv
`timescale 1ns/1ps

interface rcc_bdcr_if import rcc_bdcr_pkg::*; ();

  bdcr_u nxt;  // core to switched domain
  bdcr_u cur;  // switched domain back to core
  logic  load; // commit strobe

  // ============================================================
  // modports
  // ============================================================

  // side that requests the next value
  modport src (
    output nxt,
    output load,
    input  cur
  );

  // side that holds the current value
  modport dst (
    input  nxt,
    input  load,
    output cur
  );

endinterface

// File: logic/rcc_bdcr_seq.sv
`timescale 1ns/1ps

module rcc_bdcr_seq import rcc_bdcr_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic sw_valid,
  output logic sw_ready,
  output logic capture,
  output logic timer_start,
  input  logic timer_done,
  output logic load
);

  bdcr_state_e state;
  bdcr_state_e state_nxt;

  // ============================================================
  // state register
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ============================================================
  // next state
  // ============================================================
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (sw_valid) begin
          state_nxt = DRIVE; // write accepted
        end
      end
      DRIVE: begin
        state_nxt = SETTLE; // single cycle
      end
      SETTLE: begin
        if (timer_done) begin
          state_nxt = COMMIT;
        end
      end
      COMMIT: begin
        state_nxt = IDLE; // switched domain latches here
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  // ============================================================
  // outputs
  // ============================================================

  // only idle takes a new word, everything else is back-pressure
  assign sw_ready = (state == IDLE);

  assign capture = sw_valid & sw_ready; // shadow grabs wdata on accept

  // timer loads on the edge that enters settle
  assign timer_start = (state == DRIVE);

  assign load = (state == COMMIT);

endmodule

// File: logic/rcc_settle_timer.sv
`timescale 1ns/1ps

`include "rcc_bdcr_defs.svh"

module rcc_settle_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  output logic done
);

  localparam int CNT_W = $clog2(`RCC_SETTLE_CYCLES + 1);

  logic [CNT_W-1:0] cnt; // remaining settle cycles

  // ============================================================
  // down-counter
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (start) begin
      cnt <= CNT_W'(`RCC_SETTLE_CYCLES); // reload, also mid count
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  // last cycle of the window
  // counter reads 1 in the settle-th cycle after start
  assign done = (cnt == CNT_W'(1));

endmodule

// File: logic/rcc_bdcr_shadow.sv
`timescale 1ns/1ps

`include "rcc_bdcr_defs.svh"

module rcc_bdcr_shadow import rcc_bdcr_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   capture,
  input  logic [`RCC_BDCR_W-1:0] wdata,
  rcc_bdcr_if.src                xfer,
  input  logic                   load_in
);

  bdcr_u wr_word; // wdata with switched-domain bits stripped
  bdcr_u nxt_q;   // requested next value

  // ============================================================
  // write masking
  // ============================================================
  always_comb begin
    wr_word.raw          = wdata;
    wr_word.f.lsecssd    = 1'b0; // set by hardware only
    wr_word.f.rsvd_14_11 = '0;
    wr_word.f.rsvd_7     = 1'b0;
    wr_word.f.rsvd_1     = 1'b0;
  end

  // ============================================================
  // next-value register
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nxt_q.raw <= `RCC_BDCR_RST;
    end else if (capture) begin
      nxt_q <= wr_word;
    end
  end

  assign xfer.nxt  = nxt_q;
  assign xfer.load = load_in; // commit strobe from sequencer

endmodule

// File: logic/rcc_vsw_dft_sig_loopback.sv
`timescale 1ns/1ps

module rcc_vsw_dft_sig_loopback import rcc_bdcr_pkg::*; (
  input  logic    testmode,
  rcc_bdcr_if.dst func, // from core shadow
  rcc_bdcr_if.src gen   // to switched domain
);

  bdcr_u test_nxt; // remap of the current value

  // ============================================================
  // test remap
  // ============================================================
  always_comb begin
    test_nxt.raw        = '0; // reserved and lsecssd stay zero
    test_nxt.f.bdrst    = gen.cur.f.bdrst;
    test_nxt.f.lsebyp   = gen.cur.f.lsebyp;
    test_nxt.f.lsecsson = gen.cur.f.lsecssd;
    test_nxt.f.lsedrv   = gen.cur.f.lsedrv;
    test_nxt.f.lseon    = gen.cur.f.lsecsson;
    test_nxt.f.rtcen    = gen.cur.f.lseon ^ gen.cur.f.rtcen;
    test_nxt.f.rtcsel   = gen.cur.f.rtcsel;
  end

  // ============================================================
  // test mux
  // ============================================================

  // testmode 0 functional, 1 loopback
  assign gen.nxt = testmode ? test_nxt : func.nxt;

  assign gen.load = func.load; // strobe untouched

  // current value returns to the core as is
  assign func.cur = gen.cur;

endmodule

// File: logic/rcc_vsw_bdcr.sv
`timescale 1ns/1ps

`include "rcc_bdcr_defs.svh"

module rcc_vsw_bdcr import rcc_bdcr_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  rcc_bdcr_if.dst xfer,
  input  logic    lse_css_fail
);

  bdcr_u cur_q;   // switched-domain register
  bdcr_u cur_d;
  logic  css_set; // failure seen with css armed

  // ============================================================
  // next value
  // ============================================================
  always_comb begin
    css_set = lse_css_fail & cur_q.f.lsecsson & cur_q.f.lseon & ~cur_q.f.bdrst;
    cur_d   = cur_q;
    if (xfer.load) begin
      cur_d                = xfer.nxt;
      cur_d.f.lsecssd      = cur_q.f.lsecssd | css_set; // own bit, not from core
      cur_d.f.rsvd_14_11   = '0;
      cur_d.f.rsvd_7       = 1'b0;
      cur_d.f.rsvd_1       = 1'b0;
      if (cur_d.f.bdrst) begin
        // backup reset wipes the domain, detect flag included
        cur_d.raw     = '0;
        cur_d.f.bdrst = 1'b1;
      end
    end else if (css_set) begin
      cur_d.f.lsecssd = 1'b1; // sticky until bdrst commit
    end
  end

  // ============================================================
  // register
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_q.raw <= `RCC_BDCR_RST;
    end else begin
      cur_q <= cur_d;
    end
  end

  assign xfer.cur = cur_q;

endmodule

// File: logic/rcc_bdcr_top.sv
`timescale 1ns/1ps

`include "rcc_bdcr_defs.svh"

module rcc_bdcr_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   testmode,
  input  logic                   sw_valid,
  output logic                   sw_ready,
  input  logic [`RCC_BDCR_W-1:0] sw_wdata,
  output logic [`RCC_BDCR_W-1:0] sw_rdata,
  input  logic                   lse_css_fail
);

  logic capture;     // accept edge, shadow capture
  logic timer_start;
  logic timer_done;
  logic load;        // commit strobe

  rcc_bdcr_if func_if (); // shadow to loopback
  rcc_bdcr_if gen_if ();  // loopback to switched domain

  // ============================================================
  // core side
  // ============================================================
  rcc_bdcr_seq u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .sw_valid    (sw_valid),
    .sw_ready    (sw_ready),
    .capture     (capture),
    .timer_start (timer_start),
    .timer_done  (timer_done),
    .load        (load)
  );

  rcc_settle_timer u_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .start (timer_start),
    .done  (timer_done)
  );

  rcc_bdcr_shadow u_shadow (
    .clk     (clk),
    .rst_n   (rst_n),
    .capture (capture),
    .wdata   (sw_wdata),
    .xfer    (func_if.src),
    .load_in (load)
  );

  // ============================================================
  // crossing and switched domain
  // ============================================================
  rcc_vsw_dft_sig_loopback u_loopback (
    .testmode (testmode),
    .func     (func_if.dst),
    .gen      (gen_if.src)
  );

  rcc_vsw_bdcr u_vsw (
    .clk          (clk),
    .rst_n        (rst_n),
    .xfer         (gen_if.dst),
    .lse_css_fail (lse_css_fail)
  );

  assign sw_rdata = gen_if.cur.raw; // readback is the current value

endmodule

// File: tb/rcc_bdcr_properties.sv
`timescale 1ns/1ps

`include "rcc_bdcr_defs.svh"

module rcc_bdcr_properties import rcc_bdcr_pkg::*; (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   testmode,
  input logic                   sw_valid,
  input logic                   sw_ready,
  input logic [`RCC_BDCR_W-1:0] sw_wdata,
  input logic [`RCC_BDCR_W-1:0] sw_rdata,
  input logic                   lse_css_fail,
  input bdcr_state_e            state
);

  localparam logic [15:0] NO_CSSD = 16'hFFBF; // every bit except lsecssd

  int          fail_cnt = 0;
  logic [15:0] acc_word;    // last accepted write
  logic [15:0] commit_exp;  // expected word after this commit with lsecssd zero
  logic [15:0] exp_q;
  logic [15:0] rdata_q;
  logic [3:0]  ready_edges; // edges since accept with ready low
  logic        bdrst_commit;
  logic        css_armed;

  // ============================================================
  // reference rules
  // ============================================================
  function automatic logic [15:0] func_exp(input logic [15:0] w);
    if (w[15]) begin
      return 16'h8000; // backup reset clears the rest
    end
    return w & 16'h073D; // writable fields only
  endfunction

  function automatic logic [15:0] remap_cur(input logic [15:0] c);
    logic [15:0] r;
    r      = '0;
    r[15]  = c[15];
    r[10]  = c[0] ^ c[10];
    r[9:8] = c[9:8];
    r[5]   = c[6];
    r[4:3] = c[4:3];
    r[2]   = c[2];
    r[0]   = c[5];
    if (r[15]) begin
      r = 16'h8000;
    end
    return r;
  endfunction

  assign commit_exp   = testmode ? remap_cur(sw_rdata) : func_exp(acc_word);
  assign bdrst_commit = (state == COMMIT) && commit_exp[15];
  assign css_armed    = lse_css_fail & sw_rdata[0] & sw_rdata[5] & ~sw_rdata[15];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_word    <= '0;
      exp_q       <= '0;
      rdata_q     <= '0;
      ready_edges <= '0;
    end else begin
      exp_q   <= commit_exp;
      rdata_q <= sw_rdata;
      if (sw_valid && sw_ready) begin
        acc_word    <= sw_wdata;
        ready_edges <= '0;
      end else if (!sw_ready) begin
        ready_edges <= ready_edges + 1'b1;
      end
    end
  end

  // ============================================================
  // handshake
  // ============================================================
  a_ready_fall: assert property (@(posedge clk) disable iff (!rst_n)
    (sw_valid && sw_ready) |=> !sw_ready)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAIL %0t sw_ready expected 0 actual %b", $time, sw_ready);
    end

  a_ready_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(sw_ready) |-> ready_edges == 4'(`RCC_SETTLE_CYCLES + 2))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAIL %0t ready_edges expected %0d actual %0d", $time,
             `RCC_SETTLE_CYCLES + 2, ready_edges);
    end

  a_drive_entry: assert property (@(posedge clk) disable iff (!rst_n)
    (state == DRIVE) |-> $past(sw_valid && sw_ready))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAIL %0t sequencer entered DRIVE without an accepted write", $time);
    end

  // ============================================================
  // register contents
  // ============================================================
  a_commit_value: assert property (@(posedge clk) disable iff (!rst_n)
    (state == COMMIT) |=> (sw_rdata & NO_CSSD) == exp_q)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAIL %0t sw_rdata expected %h actual %h", $time, exp_q, sw_rdata & NO_CSSD);
    end

  a_hold_value: assert property (@(posedge clk) disable iff (!rst_n)
    (state != COMMIT) |=> (sw_rdata & NO_CSSD) == (rdata_q & NO_CSSD))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAIL %0t sw_rdata expected %h actual %h", $time,
             rdata_q & NO_CSSD, sw_rdata & NO_CSSD);
    end

  a_bdrst_clear: assert property (@(posedge clk) disable iff (!rst_n)
    bdrst_commit |=> sw_rdata == 16'h8000)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAIL %0t sw_rdata expected 8000 actual %h", $time, sw_rdata);
    end

  // ============================================================
  // clock-security detect
  // ============================================================
  a_css_keep: assert property (@(posedge clk) disable iff (!rst_n)
    (css_armed || sw_rdata[6]) && !bdrst_commit |=> sw_rdata[6])
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAIL %0t lsecssd expected 1 actual %b", $time, sw_rdata[6]);
    end

  a_css_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !sw_rdata[6] && !css_armed |=> !sw_rdata[6])
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAIL %0t lsecssd expected 0 actual %b", $time, sw_rdata[6]);
    end

  // holds during reset and on the first edge after release
  a_reset_state: assert property (@(posedge clk)
    (!rst_n || $rose(rst_n)) |-> (sw_rdata == '0) && sw_ready)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAIL %0t sw_rdata expected 0000 actual %h, sw_ready expected 1 actual %b",
             $time, sw_rdata, sw_ready);
    end

endmodule

// File: tb/tb_rcc_bdcr.sv
`timescale 1ns/1ps

`include "rcc_bdcr_defs.svh"

module tb_rcc_bdcr;

  localparam int READY_TIMEOUT = 40; // cycles
  localparam int NUM_WRITES    = 60;

  logic                   clk;
  logic                   rst_n;
  logic                   testmode;
  logic                   sw_valid;
  logic                   sw_ready;
  logic [`RCC_BDCR_W-1:0] sw_wdata;
  logic [`RCC_BDCR_W-1:0] sw_rdata;
  logic                   lse_css_fail;
  logic [31:0]            lfsr_q; // stimulus source

  rcc_bdcr_top u_rcc_bdcr_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .testmode     (testmode),
    .sw_valid     (sw_valid),
    .sw_ready     (sw_ready),
    .sw_wdata     (sw_wdata),
    .sw_rdata     (sw_rdata),
    .lse_css_fail (lse_css_fail)
  );

  bind rcc_bdcr_top rcc_bdcr_properties u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .testmode     (testmode),
    .sw_valid     (sw_valid),
    .sw_ready     (sw_ready),
    .sw_wdata     (sw_wdata),
    .sw_rdata     (sw_rdata),
    .lse_css_fail (lse_css_fail),
    .state        (u_seq.state)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // ============================================================
  // stimulus helpers
  // ============================================================

  // 32-bit fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[14:0], lfsr_q[0]}; // one step per bit
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!sw_ready) begin
      @(posedge clk);
      #1;
      n = n + 1;
      if (n > READY_TIMEOUT) begin
        $display("FAIL %0t: sw_ready stayed low for %0d cycles", $time, n);
        $display("*** FAILED ***");
        $fatal(1, "timeout waiting for sw_ready");
      end
    end
  endtask

  // rst_n low for three rising edges, released 1 ns after the third
  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // one write task entered and left 1 ns after a rising edge
  task automatic run_write();
    logic [15:0] word;
    logic [15:0] r;
    take_bits(16, word);
    take_bits(2, r);
    word[15] = word[15] & r[0] & r[1]; // keep backup reset rare
    take_bits(2, r);
    testmode = &r[1:0];
    take_bits(2, r);
    lse_css_fail = &r[1:0];
    sw_wdata     = word;
    sw_valid     = 1'b1; // may sit back-pressured here
    wait_ready();
    @(posedge clk); // accept edge
    #1;
    sw_valid     = 1'b0;
    lse_css_fail = 1'b0;
    take_bits(3, r);
    for (int i = 0; i < int'(r); i++) begin
      @(posedge clk);
      #1;
    end
  endtask

  // stop at the first failed assertion
  always @(negedge clk) begin
    if (u_rcc_bdcr_top.u_props.fail_cnt != 0) begin
      $display("FAIL %0t: a concurrent assertion on the DUT failed", $time);
      $display("*** FAILED ***");
      $fatal(1, "assertion failure");
    end
  end

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    lfsr_q       = 32'd96006;
    rst_n        = 1'b1;
    testmode     = 1'b0;
    sw_valid     = 1'b0;
    sw_wdata     = '0;
    lse_css_fail = 1'b0;
    #1;
    apply_reset();
    for (int t = 0; t < NUM_WRITES; t++) begin
      if (t == NUM_WRITES / 2) begin
        apply_reset(); // second reset with the register loaded
      end
      run_write();
    end
    wait_ready();
    repeat (2) @(posedge clk); // last commit check samples here
    #1;
    if (u_rcc_bdcr_top.u_props.fail_cnt == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("FAIL %0t: %0d assertion failures", $time, u_rcc_bdcr_top.u_props.fail_cnt);
      $display("*** FAILED ***");
      $fatal(1, "assertion failures at end of run");
    end
  end

endmodule

// File: sim.f
+incdir+include
logic/rcc_bdcr_pkg.sv
logic/rcc_bdcr_if.sv
logic/rcc_bdcr_seq.sv
logic/rcc_settle_timer.sv
logic/rcc_bdcr_shadow.sv
logic/rcc_vsw_dft_sig_loopback.sv
logic/rcc_vsw_bdcr.sv
logic/rcc_bdcr_top.sv
tb/rcc_bdcr_properties.sv
tb/tb_rcc_bdcr.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_rcc_bdcr
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
RUN_ARGS   := +verilator+error+limit+100
PASS_TEXT  := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -qF '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
